//--- build.f
source/riscv_core_pkg.sv
source/riscv_core_hazard_unit.sv
source/riscv_core_pipe_tracker.sv
source/riscv_core_muldiv_unit.sv
source/riscv_core_hazard_top.sv
testbench/riscv_core_hazard_tb.sv

//--- Makefile
TOP := riscv_core_hazard_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f build.f -Mdir obj_dir -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; \
		echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

//--- testbench/riscv_core_hazard_tb.sv
`timescale 1ns/10ps

module riscv_core_hazard_tb
    import riscv_core_pkg::*;
();

    logic            clk;
    logic            rst_n;
    instr_ctrl_t     if_instr;
    logic [XLEN-1:0] ex_operand_a;
    logic [XLEN-1:0] ex_operand_b;
    logic            pcsrc_ex;
    logic            illegal_instr;
    logic            icache_stall;
    logic            dcache_stall;

    fwd_sel_e        forwarda_ex;
    fwd_sel_e        forwardb_ex;
    stall_vec_t      stall;
    flush_vec_t      flush;
    logic            exception;
    logic            mdiv_done;
    logic [XLEN-1:0] mdiv_result;
    instr_ctrl_t     ex_ctrl;

    // Shadow pipeline and multiply/divide expectations
    instr_ctrl_t     m_id;
    instr_ctrl_t     m_ex;
    instr_ctrl_t     m_mem;
    instr_ctrl_t     m_wb;
    int              mcnt;
    logic [XLEN-1:0] exp_result;
    logic            exp_err;

    logic [31:0]     rng_state;
    int              errors;
    int              mdiv_ops;
    int              random_cycles;

    logic            mdiv_in_ex;
    logic            mdiv_run_exp;
    logic            mdiv_done_exp;
    logic            lu_exp;
    fwd_sel_e        fwda_exp;
    fwd_sel_e        fwdb_exp;
    stall_vec_t      exp_stall;
    flush_vec_t      exp_flush;

    riscv_core_hazard_top riscv_core_hazard_top_i (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_if_instr      (if_instr),
        .i_ex_operand_a  (ex_operand_a),
        .i_ex_operand_b  (ex_operand_b),
        .i_pcsrc_ex      (pcsrc_ex),
        .i_illegal_instr (illegal_instr),
        .i_icache_stall  (icache_stall),
        .i_dcache_stall  (dcache_stall),
        .o_forwarda_ex   (forwarda_ex),
        .o_forwardb_ex   (forwardb_ex),
        .o_stall         (stall),
        .o_flush         (flush),
        .o_exception     (exception),
        .o_mdiv_done     (mdiv_done),
        .o_mdiv_result   (mdiv_result),
        .o_ex_ctrl       (ex_ctrl)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [XLEN-1:0] random_word();
        return {next_random(), next_random()};
    endfunction

    // Small register indices so that matches are frequent
    function automatic instr_ctrl_t random_instr();
        logic [31:0] r;
        instr_ctrl_t ins;
        r = next_random();
        ins = CTRL_BUBBLE;
        if (r[3:0] != 4'd0)
        begin
            ins.valid     = 1'b1;
            ins.rs1       = {3'b000, r[5:4]};
            ins.rs2       = {3'b000, r[7:6]};
            ins.rd        = {3'b000, r[9:8]};
            ins.resultsrc = (r[13:12] == 2'b00) ? RES_LOAD : RES_ALU;
            ins.regwrite  = r[10] || (r[13:12] == 2'b00);
        end
        return ins;
    endfunction

    function automatic mdiv_op_e pick_mop(input logic [2:0] v);
        case (v)
            3'd0:    return MOP_MUL;
            3'd1:    return MOP_DIV;
            3'd2:    return MOP_DIVU;
            3'd3:    return MOP_REM;
            default: return MOP_REMU;
        endcase
    endfunction

    // Newest writer wins and x0 always reads the register file
    function automatic fwd_sel_e expected_fwd
    (
        input logic [REG_ADDR_W-1:0] rs,
        input instr_ctrl_t           mem_s,
        input instr_ctrl_t           wb_s
    );
        logic from_mem;
        logic from_wb;
        from_mem = mem_s.regwrite && (mem_s.rd == rs) && (|rs);
        from_wb  = wb_s.regwrite && (wb_s.rd == rs) && (|rs);
        if (from_mem)
        begin
            return FWD_MEM;
        end
        if (from_wb)
        begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    function automatic logic signed_ovf(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        return (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == {XLEN{1'b1}});
    endfunction

    function automatic logic [XLEN-1:0] expected_mdiv
    (
        input mdiv_op_e        op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic [XLEN-1:0]        res;
        sa = a;
        sb = b;
        res = '0;
        if (op == MOP_MUL)
        begin
            res = a * b;
        end
        else if ((op == MOP_DIV) || (op == MOP_DIVU))
        begin
            if (b == '0)
                res = '1;
            else if ((op == MOP_DIV) && signed_ovf(a, b))
                res = a;
            else if (op == MOP_DIV)
                res = sa / sb;
            else
                res = a / b;
        end
        else
        begin
            if (b == '0)
                res = a;
            else if ((op == MOP_REM) && signed_ovf(a, b))
                res = '0;
            else if (op == MOP_REM)
                res = sa % sb;
            else
                res = a % b;
        end
        return res;
    endfunction

    function automatic logic expected_mdiv_err
    (
        input mdiv_op_e        op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic is_signed;
        is_signed = (op == MOP_DIV) || (op == MOP_REM);
        return ((op != MOP_MUL) && (b == '0)) || (is_signed && signed_ovf(a, b));
    endfunction

    // Stage model follows the DUT's own stall and flush decisions
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            m_id  <= CTRL_BUBBLE;
            m_ex  <= CTRL_BUBBLE;
            m_mem <= CTRL_BUBBLE;
            m_wb  <= CTRL_BUBBLE;
            mcnt  <= 0;
        end
        else
        begin
            if (flush.id)
                m_id <= CTRL_BUBBLE;
            else if (!stall.id)
                m_id <= if_instr;
            if (flush.ex)
                m_ex <= CTRL_BUBBLE;
            else if (!stall.ex)
                m_ex <= m_id;
            if (!stall.mem)
                m_mem <= stall.ex ? CTRL_BUBBLE : m_ex;
            if (!stall.wb)
                m_wb <= stall.mem ? CTRL_BUBBLE : m_mem;
            // Cycles spent by the current instruction in EX
            if (!stall.ex || flush.ex)
                mcnt <= 0;
            else if (mdiv_in_ex)
                mcnt <= mcnt + 1;
        end
    end

    assign mdiv_in_ex    = m_ex.valid && m_ex.is_mdiv;
    assign mdiv_run_exp  = mdiv_in_ex && (mcnt < MDIV_STEPS);
    assign mdiv_done_exp = mdiv_in_ex && (mcnt == MDIV_STEPS);
    assign lu_exp        = m_ex.valid && (m_ex.resultsrc == RES_LOAD) &&
                           ((m_id.rs1 == m_ex.rd) || (m_id.rs2 == m_ex.rd));
    assign fwda_exp      = expected_fwd(m_ex.rs1, m_mem, m_wb);
    assign fwdb_exp      = expected_fwd(m_ex.rs2, m_mem, m_wb);

    // Full stall and flush vectors from the model's requests
    assign exp_stall.fetch = lu_exp || mdiv_run_exp || icache_stall || dcache_stall;
    assign exp_stall.id    = lu_exp || mdiv_run_exp || dcache_stall;
    assign exp_stall.ex    = mdiv_run_exp || dcache_stall;
    assign exp_stall.mem   = mdiv_run_exp || dcache_stall;
    assign exp_stall.wb    = mdiv_run_exp;
    assign exp_flush.ex    = lu_exp || pcsrc_ex;
    assign exp_flush.id    = pcsrc_ex;

    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] %0t %s", $time, msg);
    endtask

    stage_model_a: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_ctrl == m_ex) && (riscv_core_hazard_top_i.id_ctrl == m_id) &&
        (riscv_core_hazard_top_i.mem_ctrl == m_mem) &&
        (riscv_core_hazard_top_i.wb_ctrl == m_wb))
        else report_error("stage registers differ from the stage model");

    forwarding_a: assert property (@(posedge clk) disable iff (!rst_n)
        (forwarda_ex == fwda_exp) && (forwardb_ex == fwdb_exp))
        else report_error("forwarding select differs from MEM-before-WB rule");

    stall_vec_a: assert property (@(posedge clk) disable iff (!rst_n)
        stall == exp_stall)
        else report_error("stall vector differs from the requests in flight");

    flush_vec_a: assert property (@(posedge clk) disable iff (!rst_n)
        flush == exp_flush)
        else report_error("flush vector differs from the requests in flight");

    load_use_now_a: assert property (@(posedge clk) disable iff (!rst_n)
        lu_exp |-> (stall.fetch && stall.id && flush.ex))
        else report_error("load-use did not stall IF/ID and flush EX");

    load_use_next_a: assert property (@(posedge clk) disable iff (!rst_n)
        (lu_exp && !pcsrc_ex) |=> ((ex_ctrl == CTRL_BUBBLE) &&
        (riscv_core_hazard_top_i.id_ctrl == $past(riscv_core_hazard_top_i.id_ctrl))))
        else report_error("load-use did not leave a bubble in EX with ID held");

    icache_a: assert property (@(posedge clk) disable iff (!rst_n)
        (icache_stall && !dcache_stall && !lu_exp && !mdiv_run_exp) |->
        (stall.fetch && !stall.id && !stall.ex && !stall.mem && !stall.wb))
        else report_error("instruction cache stall vector wrong");

    dcache_a: assert property (@(posedge clk) disable iff (!rst_n)
        (dcache_stall && !mdiv_run_exp) |->
        (stall.fetch && stall.id && stall.ex && stall.mem && !stall.wb))
        else report_error("data cache stall vector wrong");

    branch_now_a: assert property (@(posedge clk) disable iff (!rst_n)
        pcsrc_ex |-> (flush.id && flush.ex))
        else report_error("taken branch did not flush ID and EX");

    branch_next_a: assert property (@(posedge clk) disable iff (!rst_n)
        pcsrc_ex |=> ((ex_ctrl == CTRL_BUBBLE) &&
        (riscv_core_hazard_top_i.id_ctrl == CTRL_BUBBLE)))
        else report_error("ID or EX not empty after a taken branch");

    mdiv_run_a: assert property (@(posedge clk) disable iff (!rst_n)
        mdiv_run_exp |-> (stall.ex && !mdiv_done))
        else report_error("multiply/divide stall or done wrong while running");

    mdiv_done_a: assert property (@(posedge clk) disable iff (!rst_n)
        mdiv_done_exp |-> (mdiv_done && !stall.ex && (mdiv_result == exp_result)))
        else report_error("multiply/divide done cycle or result wrong");

    mdiv_early_a: assert property (@(posedge clk) disable iff (!rst_n)
        mdiv_done |-> mdiv_done_exp)
        else report_error("multiply/divide done at the wrong cycle");

    exception_a: assert property (@(posedge clk) disable iff (!rst_n)
        exception == (illegal_instr || (mdiv_done_exp && exp_err)))
        else report_error("exception flag wrong");

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Errors: %0d, multiply/divide ops: %0d", errors, mdiv_ops);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic random_traffic(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++)
        begin
            @(posedge clk);
            r = next_random();
            // Front end holds its instruction while fetch is stalled
            if (!stall.fetch)
                if_instr <= random_instr();
            pcsrc_ex      <= (r[3:0] == 4'd0);
            icache_stall  <= (r[6:4] == 3'd0);
            dcache_stall  <= (r[9:7] == 3'd0);
            illegal_instr <= (r[13:10] == 4'd0);
            ex_operand_a  <= random_word();
            ex_operand_b  <= random_word();
            random_cycles++;
        end
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        @(posedge clk);
        if_instr      <= CTRL_BUBBLE;
        pcsrc_ex      <= 1'b0;
        icache_stall  <= 1'b0;
        dcache_stall  <= 1'b0;
        illegal_instr <= 1'b0;
        while (m_id.valid || m_ex.valid || m_mem.valid || m_wb.valid)
        begin
            if (waited == 20)
                abort_on_timeout("the pipeline to drain");
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic run_mdiv(input mdiv_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        instr_ctrl_t ins;
        logic [31:0] r;
        int          waited;
        r = next_random();
        ins = CTRL_BUBBLE;
        ins.valid     = 1'b1;
        ins.rs1       = {3'b000, r[1:0]};
        ins.rs2       = {3'b000, r[3:2]};
        ins.rd        = {3'b000, r[5:4]};
        ins.regwrite  = 1'b1;
        ins.resultsrc = RES_MDIV;
        ins.is_mdiv   = 1'b1;
        ins.mop       = op;
        @(posedge clk);
        if_instr     <= ins;
        ex_operand_a <= a;
        ex_operand_b <= b;
        exp_result   <= expected_mdiv(op, a, b);
        exp_err      <= expected_mdiv_err(op, a, b);
        @(posedge clk);
        if_instr <= CTRL_BUBBLE;
        waited = 0;
        while (!mdiv_done)
        begin
            if (waited == MDIV_STEPS + 8)
                abort_on_timeout("multiply/divide done");
            @(posedge clk);
            r = next_random();
            illegal_instr <= (r[3:0] == 4'd0);
            waited++;
        end
        illegal_instr <= 1'b0;
        mdiv_ops++;
    endtask

    initial
    begin
        logic [31:0]     r;
        logic [XLEN-1:0] min_val;
        rng_state     = 32'hd7fb4a16;
        errors        = 0;
        mdiv_ops      = 0;
        random_cycles = 0;
        min_val       = {1'b1, {(XLEN-1){1'b0}}};
        rst_n         = 1'b0;
        if_instr      = CTRL_BUBBLE;
        ex_operand_a  = '0;
        ex_operand_b  = '0;
        pcsrc_ex      = 1'b0;
        illegal_instr = 1'b0;
        icache_stall  = 1'b0;
        dcache_stall  = 1'b0;
        exp_result    = '0;
        exp_err       = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        random_traffic(600);
        drain_pipeline();

        // Corner cases of the M extension
        run_mdiv(MOP_DIV, min_val, '1);
        run_mdiv(MOP_REM, min_val, '1);
        run_mdiv(MOP_DIV, random_word(), '0);
        run_mdiv(MOP_DIVU, random_word(), '0);
        run_mdiv(MOP_REMU, random_word(), '0);
        run_mdiv(MOP_REM, XLEN'(-7), XLEN'(2));
        run_mdiv(MOP_MUL, random_word(), random_word());
        for (int i = 0; i < 16; i++)
        begin
            r = next_random();
            run_mdiv(pick_mop(r[2:0]), random_word(),
                     (r[5:3] == 3'd0) ? '0 : (random_word() >> r[11:6]));
        end
        drain_pipeline();

        $display("Errors: %0d, multiply/divide ops: %0d, random cycles: %0d",
                 errors, mdiv_ops, random_cycles);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- source/riscv_core_hazard_top.sv
`timescale 1ns/10ps

module riscv_core_hazard_top
    import riscv_core_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,

    // Decode and datapath inputs
    input  instr_ctrl_t     i_if_instr,
    input  logic [XLEN-1:0] i_ex_operand_a,
    input  logic [XLEN-1:0] i_ex_operand_b,
    input  logic            i_pcsrc_ex,
    input  logic            i_illegal_instr,
    input  logic            i_icache_stall,
    input  logic            i_dcache_stall,

    // Hazard control
    output fwd_sel_e        o_forwarda_ex,
    output fwd_sel_e        o_forwardb_ex,
    output stall_vec_t      o_stall,
    output flush_vec_t      o_flush,
    output logic            o_exception,

    // Multiply/divide result for the EX result mux
    output logic            o_mdiv_done,
    output logic [XLEN-1:0] o_mdiv_result,
    output instr_ctrl_t     o_ex_ctrl
);

    instr_ctrl_t  id_ctrl;
    instr_ctrl_t  mem_ctrl;
    instr_ctrl_t  wb_ctrl;
    mdiv_status_t mdiv_status;

    riscv_core_pipe_tracker riscv_core_pipe_tracker_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_if_instr (i_if_instr),
        .i_stall    (o_stall),
        .i_flush    (o_flush),
        .o_id_ctrl  (id_ctrl),
        .o_ex_ctrl  (o_ex_ctrl),
        .o_mem_ctrl (mem_ctrl),
        .o_wb_ctrl  (wb_ctrl)
    );

    riscv_core_hazard_unit riscv_core_hazard_unit_i (
        .i_id_ctrl       (id_ctrl),
        .i_ex_ctrl       (o_ex_ctrl),
        .i_mem_ctrl      (mem_ctrl),
        .i_wb_ctrl       (wb_ctrl),
        .i_pcsrc_ex      (i_pcsrc_ex),
        .i_illegal_instr (i_illegal_instr),
        .i_mdiv_status   (mdiv_status),
        .i_icache_stall  (i_icache_stall),
        .i_dcache_stall  (i_dcache_stall),
        .o_forwarda_ex   (o_forwarda_ex),
        .o_forwardb_ex   (o_forwardb_ex),
        .o_stall         (o_stall),
        .o_flush         (o_flush),
        .o_exception     (o_exception)
    );

    riscv_core_muldiv_unit riscv_core_muldiv_unit_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_ex_ctrl   (o_ex_ctrl),
        .i_operand_a (i_ex_operand_a),
        .i_operand_b (i_ex_operand_b),
        .o_status    (mdiv_status),
        .o_result    (o_mdiv_result)
    );

    assign o_mdiv_done = mdiv_status.done;

endmodule

//--- source/riscv_core_muldiv_unit.sv
`timescale 1ns/10ps

module riscv_core_muldiv_unit
    import riscv_core_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst_n,

    // Instruction currently in EX
    input  instr_ctrl_t      i_ex_ctrl,
    input  logic [XLEN-1:0]  i_operand_a,
    input  logic [XLEN-1:0]  i_operand_b,

    output mdiv_status_t     o_status,
    output logic [XLEN-1:0]  o_result
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } mdiv_state_e;

    mdiv_state_e           state_q;
    logic [MDIV_CNT_W-1:0] cnt_q;
    logic                  start;

    // Iteration registers, shared by multiply and divide
    logic [XLEN:0]         acc_q;
    logic [XLEN-1:0]       wa_q;
    logic [XLEN-1:0]       wb_q;
    mdiv_op_e              op_q;
    logic                  neg_quo_q;
    logic                  neg_rem_q;
    logic                  divby0_q;
    logic                  ovf_q;

    // Operand preparation at start
    logic                  init_mul;
    logic                  init_signed;
    logic                  sign_a;
    logic                  sign_b;
    logic [XLEN-1:0]       init_a;
    logic [XLEN-1:0]       init_b;

    // One iteration step
    mdiv_op_e              cur_op;
    logic [XLEN:0]         src_acc;
    logic [XLEN-1:0]       src_wa;
    logic [XLEN-1:0]       src_wb;
    logic [XLEN:0]         rem_shift;
    logic [XLEN:0]         rem_diff;
    logic [XLEN:0]         nxt_acc;
    logic [XLEN-1:0]       nxt_wa;
    logic [XLEN-1:0]       nxt_wb;

    logic [XLEN-1:0]       quotient;
    logic [XLEN-1:0]       remainder;

    assign start = (state_q == ST_IDLE) && i_ex_ctrl.valid && i_ex_ctrl.is_mdiv;

    always_comb
    begin : init_proc
        init_mul    = (i_ex_ctrl.mop == MOP_MUL);
        init_signed = (i_ex_ctrl.mop == MOP_DIV) || (i_ex_ctrl.mop == MOP_REM);
        sign_a      = init_signed && i_operand_a[XLEN-1];
        sign_b      = init_signed && i_operand_b[XLEN-1];
        // Divide works on magnitudes, multiply on raw bits
        init_a      = (!init_mul && sign_a) ? -i_operand_a : i_operand_a;
        init_b      = (!init_mul && sign_b) ? -i_operand_b : i_operand_b;
    end

    always_comb
    begin : step_proc
        // First step is taken straight from the operands
        cur_op  = (state_q == ST_IDLE) ? i_ex_ctrl.mop : op_q;
        src_acc = (state_q == ST_IDLE) ? '0 : acc_q;
        src_wa  = (state_q == ST_IDLE) ? init_a : wa_q;
        src_wb  = (state_q == ST_IDLE) ? init_b : wb_q;

        rem_shift = {src_acc[XLEN-1:0], src_wa[XLEN-1]};
        rem_diff  = rem_shift - {1'b0, src_wb};

        if (cur_op == MOP_MUL)
        begin
            // Shift-add, low half of the product only
            nxt_acc = src_wb[0] ? {1'b0, src_acc[XLEN-1:0] + src_wa} : src_acc;
            nxt_wa  = src_wa << 1;
            nxt_wb  = src_wb >> 1;
        end
        else if (!rem_diff[XLEN])
        begin
            nxt_acc = rem_diff;
            nxt_wa  = {src_wa[XLEN-2:0], 1'b1};
            nxt_wb  = src_wb;
        end
        else
        begin
            // Restore, divisor did not fit
            nxt_acc = rem_shift;
            nxt_wa  = {src_wa[XLEN-2:0], 1'b0};
            nxt_wb  = src_wb;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin : fsm_proc
        if (!i_rst_n)
        begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        state_q <= ST_RUN;
                        cnt_q   <= MDIV_CNT_W'(1);
                    end
                end
                ST_RUN:
                begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == MDIV_CNT_W'(MDIV_STEPS - 1))
                    begin
                        state_q <= ST_DONE;
                    end
                end
                default:
                begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin : datapath_proc
        if (start)
        begin
            op_q      <= i_ex_ctrl.mop;
            neg_quo_q <= sign_a ^ sign_b;
            neg_rem_q <= sign_a;
            divby0_q  <= !init_mul && (i_operand_b == '0);
            ovf_q     <= init_signed && (i_operand_a == {1'b1, {(XLEN-1){1'b0}}}) &&
                         (i_operand_b == '1);
        end
        if (start || (state_q == ST_RUN))
        begin
            acc_q <= nxt_acc;
            wa_q  <= nxt_wa;
            wb_q  <= nxt_wb;
        end
    end

    always_comb
    begin : result_proc
        quotient  = neg_quo_q ? -wa_q : wa_q;
        remainder = neg_rem_q ? -acc_q[XLEN-1:0] : acc_q[XLEN-1:0];
        case (op_q)
            MOP_MUL:           o_result = acc_q[XLEN-1:0];
            MOP_DIV, MOP_DIVU: o_result = divby0_q ? '1 : quotient;
            default:           o_result = remainder;
        endcase
    end

    // Busy covers the start cycle through the done cycle
    assign o_status.busy   = start || (state_q != ST_IDLE);
    assign o_status.done   = (state_q == ST_DONE);
    assign o_status.divby0 = (state_q == ST_DONE) && divby0_q;
    assign o_status.ovf    = (state_q == ST_DONE) && ovf_q;

endmodule

//--- source/riscv_core_pipe_tracker.sv
`timescale 1ns/10ps

module riscv_core_pipe_tracker
    import riscv_core_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,

    // Decoded instruction from fetch/decode
    input  instr_ctrl_t i_if_instr,

    // Pipeline control from the hazard unit
    input  stall_vec_t  i_stall,
    input  flush_vec_t  i_flush,

    // Stage contents
    output instr_ctrl_t o_id_ctrl,
    output instr_ctrl_t o_ex_ctrl,
    output instr_ctrl_t o_mem_ctrl,
    output instr_ctrl_t o_wb_ctrl
);

    instr_ctrl_t id_q;
    instr_ctrl_t ex_q;
    instr_ctrl_t mem_q;
    instr_ctrl_t wb_q;

    // ID stage, flush wins over stall
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin : id_stage_proc
        if (!i_rst_n)
        begin
            id_q <= CTRL_BUBBLE;
        end
        else if (i_flush.id)
        begin
            id_q <= CTRL_BUBBLE;
        end
        else if (!i_stall.id)
        begin
            id_q <= i_if_instr;
        end
    end

    // EX stage, load-use and branches both flush here
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin : ex_stage_proc
        if (!i_rst_n)
        begin
            ex_q <= CTRL_BUBBLE;
        end
        else if (i_flush.ex)
        begin
            ex_q <= CTRL_BUBBLE;
        end
        else if (!i_stall.ex)
        begin
            ex_q <= id_q;
        end
    end

    // MEM stage
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin : mem_stage_proc
        if (!i_rst_n)
        begin
            mem_q <= CTRL_BUBBLE;
        end
        else if (!i_stall.mem)
        begin
            // EX held back, so nothing leaves it this cycle
            if (i_stall.ex)
            begin
                mem_q <= CTRL_BUBBLE;
            end
            else
            begin
                mem_q <= ex_q;
            end
        end
    end

    // WB stage
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin : wb_stage_proc
        if (!i_rst_n)
        begin
            wb_q <= CTRL_BUBBLE;
        end
        else if (!i_stall.wb)
        begin
            // MEM held back, insert an empty slot
            if (i_stall.mem)
            begin
                wb_q <= CTRL_BUBBLE;
            end
            else
            begin
                wb_q <= mem_q;
            end
        end
    end

    assign o_id_ctrl  = id_q;
    assign o_ex_ctrl  = ex_q;
    assign o_mem_ctrl = mem_q;
    assign o_wb_ctrl  = wb_q;

endmodule

//--- source/riscv_core_hazard_unit.sv
`timescale 1ns/10ps

module riscv_core_hazard_unit
    import riscv_core_pkg::*;
(
    // Stage control bundles
    input  instr_ctrl_t  i_id_ctrl,
    input  instr_ctrl_t  i_ex_ctrl,
    input  instr_ctrl_t  i_mem_ctrl,
    input  instr_ctrl_t  i_wb_ctrl,

    // Taken branch resolved in EX
    input  logic         i_pcsrc_ex,

    // Decoder request
    input  logic         i_illegal_instr,

    // Multiply/divide requests
    input  mdiv_status_t i_mdiv_status,

    // Cache requests
    input  logic         i_icache_stall,
    input  logic         i_dcache_stall,

    // Forwarding selects
    output fwd_sel_e     o_forwarda_ex,
    output fwd_sel_e     o_forwardb_ex,

    // Pipeline control
    output stall_vec_t   o_stall,
    output flush_vec_t   o_flush,
    output logic         o_exception
);

    logic lwstall_detection;
    logic mstall_detection;

    // MEM result is newer than WB, so it wins
    function automatic fwd_sel_e fwd_select
    (
        input logic [REG_ADDR_W-1:0] rs,
        input instr_ctrl_t           mem_ctrl,
        input instr_ctrl_t           wb_ctrl
    );
        fwd_sel_e sel;
        sel = FWD_REG;
        if ((rs == mem_ctrl.rd) && mem_ctrl.regwrite && (rs != '0))
        begin
            sel = FWD_MEM;
        end
        else if ((rs == wb_ctrl.rd) && wb_ctrl.regwrite && (rs != '0))
        begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    always_comb
    begin : forwarding_proc
        o_forwarda_ex = fwd_select(i_ex_ctrl.rs1, i_mem_ctrl, i_wb_ctrl);
        o_forwardb_ex = fwd_select(i_ex_ctrl.rs2, i_mem_ctrl, i_wb_ctrl);
    end

    always_comb
    begin : stall_proc
        // Load in EX feeding a source of the instruction in ID
        lwstall_detection = i_ex_ctrl.valid && (i_ex_ctrl.resultsrc == RES_LOAD) &&
                            ((i_id_ctrl.rs1 == i_ex_ctrl.rd) ||
                             (i_id_ctrl.rs2 == i_ex_ctrl.rd));

        // Hold everything until the iterative unit reports done
        mstall_detection  = i_mdiv_status.busy && !i_mdiv_status.done;

        o_stall.fetch = lwstall_detection || mstall_detection ||
                        i_icache_stall || i_dcache_stall;
        o_stall.id    = lwstall_detection || mstall_detection || i_dcache_stall;
        o_stall.ex    = mstall_detection || i_dcache_stall;
        o_stall.mem   = mstall_detection || i_dcache_stall;
        o_stall.wb    = mstall_detection;
    end

    always_comb
    begin : flush_proc
        // Load-use inserts a bubble into EX while ID holds
        o_flush.ex = lwstall_detection || i_pcsrc_ex;
        o_flush.id = i_pcsrc_ex;
    end

    always_comb
    begin : exceptions_proc
        o_exception = i_illegal_instr || i_mdiv_status.divby0 || i_mdiv_status.ovf;
    end

endmodule

//--- source/riscv_core_pkg.sv
package riscv_core_pkg;

    // Datapath and register file geometry
    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    // One iteration per operand bit in the multiply/divide unit
    localparam int MDIV_STEPS = XLEN;
    localparam int MDIV_CNT_W = $clog2(MDIV_STEPS);

    // Write-back source, load keeps the 01 code
    typedef enum logic [1:0] {
        RES_ALU  = 2'b00,
        RES_LOAD = 2'b01,
        RES_PC4  = 2'b10,
        RES_MDIV = 2'b11
    } result_src_e;

    // M extension operations
    typedef enum logic [2:0] {
        MOP_MUL  = 3'd0,
        MOP_DIV  = 3'd1,
        MOP_DIVU = 3'd2,
        MOP_REM  = 3'd3,
        MOP_REMU = 3'd4
    } mdiv_op_e;

    // Operand source select in EX
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_e;

    // Control bundle carried by each pipeline stage
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  regwrite;
        result_src_e           resultsrc;
        logic                  is_mdiv;
        mdiv_op_e              mop;
    } instr_ctrl_t;

    // Empty slot, writes nothing and starts nothing
    localparam instr_ctrl_t CTRL_BUBBLE = '0;

    // Fetch stall is named fetch since if is a keyword
    typedef struct packed {
        logic fetch;
        logic id;
        logic ex;
        logic mem;
        logic wb;
    } stall_vec_t;

    typedef struct packed {
        logic id;
        logic ex;
    } flush_vec_t;

    typedef struct packed {
        logic busy;
        logic done;
        logic divby0;
        logic ovf;
    } mdiv_status_t;

endpackage
